// ==== rtl/ray_pkg.sv ====
package ray_pkg;

    ////////////////////////////////////////////////////////////
    // screen and camera

    localparam int SCREEN_W = 1024;
    localparam int SCREEN_H = 768;
    // x keeps one spare bit, the scan side counts past the visible width
    localparam int PX_W = $clog2(SCREEN_W) + 1;
    localparam int PY_W = $clog2(SCREEN_H);

    // eye sits on the screen center
    localparam int CENTER_X = SCREEN_W / 2;
    localparam int CENTER_Y = SCREEN_H / 2;
    // z of every ray direction
    localparam int FOCAL = 512;

    ////////////////////////////////////////////////////////////
    // block table

    localparam int NUM_BLOCKS = 16;
    localparam int IDX_W = $clog2(NUM_BLOCKS);
    // front face edge, world units
    localparam int BLOCK_SIZE = 64;
    // saber slot, thin in x only
    localparam int SABER_INDEX = 12;
    localparam int SABER_WIDTH = 16;
    localparam int POS_W = 12;
    // unsigned z, doubles as depth t
    localparam int DEPTH_W = 14;

    ////////////////////////////////////////////////////////////
    // datapath widths and pipeline depths

    // pixel minus center, signed
    localparam int DIR_W = 12;
    // room for dir * z plus sign
    localparam int PROD_W = DIR_W + DEPTH_W + 1;
    localparam int PICK_LATENCY = 5;
    localparam int INTERSECT_LAT = 3;
    // ray reg plus intersect stages
    localparam int ALIGN_DEPTH = PICK_LATENCY - 1;

    typedef enum logic [1:0] {
        SEL_IDLE,
        SEL_SCAN,
        SEL_DRAIN
    } sel_state_t;

endpackage

// ==== rtl/ray_ifs.sv ====
`timescale 1ns/1ns

// one block per beat, selector to picker
interface block_if import ray_pkg::*; ();

    logic                     valid;
    logic [PX_W-1:0]          px;
    logic [PY_W-1:0]          py;
    logic [IDX_W-1:0]         index;
    logic signed [POS_W-1:0]  bx;
    logic signed [POS_W-1:0]  by;
    logic [DEPTH_W-1:0]       bz;
    logic                     visible;

    modport source (
        output valid, px, py, index, bx, by, bz, visible
    );

    modport sink (
        input valid, px, py, index, bx, by, bz, visible
    );

endinterface

// test result per block, picker back to selector
interface hit_if import ray_pkg::*; ();

    logic                valid;
    logic [IDX_W-1:0]    index;
    logic                hit;
    logic [DEPTH_W-1:0]  t;

    modport source (
        output valid, index, hit, t
    );

    modport sink (
        input valid, index, hit, t
    );

endinterface

// ==== rtl/does_ray_block_intersect.sv ====
`timescale 1ns/1ns

module does_ray_block_intersect import ray_pkg::*; (
    input  logic                     clk_in,
    input  logic                     rst_in,
    input  logic                     valid_in,
    input  logic signed [DIR_W-1:0]  dir_x,
    input  logic signed [DIR_W-1:0]  dir_y,
    input  logic signed [POS_W-1:0]  bx,
    input  logic signed [POS_W-1:0]  by,
    input  logic [DEPTH_W-1:0]       bz,
    input  logic                     is_saber,
    output logic                     valid_out,
    output logic                     intersects_out,
    output logic [DEPTH_W-1:0]       t_out
);

    // sign extended operands
    logic signed [PROD_W-1:0] dx_ext;
    logic signed [PROD_W-1:0] dy_ext;
    logic signed [PROD_W-1:0] bx_ext;
    logic signed [PROD_W-1:0] by_ext;
    logic signed [PROD_W-1:0] bz_ext;
    logic signed [PROD_W-1:0] width_x;

    // stage 1
    logic signed [PROD_W-1:0] s1_cross_x;
    logic signed [PROD_W-1:0] s1_cross_y;
    logic signed [PROD_W-1:0] s1_lo_x;
    logic signed [PROD_W-1:0] s1_hi_x;
    logic signed [PROD_W-1:0] s1_lo_y;
    logic signed [PROD_W-1:0] s1_hi_y;
    logic [DEPTH_W-1:0]       s1_bz;

    // stage 2
    logic [3:0]               s2_inside;
    logic                     s2_bz_nz;
    logic [DEPTH_W-1:0]       s2_bz;

    // valid rides beside the data
    logic [INTERSECT_LAT-1:0] vld_sr;

    assign dx_ext = dir_x;
    assign dy_ext = dir_y;
    assign bx_ext = bx;
    assign by_ext = by;
    // z is unsigned, pad with zeros
    assign bz_ext = {{(PROD_W-DEPTH_W){1'b0}}, bz};
    assign width_x = is_saber ? PROD_W'(SABER_WIDTH) : PROD_W'(BLOCK_SIZE);

    ////////////////////////////////////////////////////////////
    // stage 1: cross products and scaled face edges
    // dx/dz in [bx, bx+w) becomes dx*bz in [bx*f, (bx+w)*f)
    always_ff @(posedge clk_in) begin
        s1_cross_x <= dx_ext * bz_ext;
        s1_cross_y <= dy_ext * bz_ext;
        s1_lo_x <= bx_ext * PROD_W'(FOCAL);
        s1_hi_x <= (bx_ext + width_x) * PROD_W'(FOCAL);
        s1_lo_y <= by_ext * PROD_W'(FOCAL);
        s1_hi_y <= (by_ext + PROD_W'(BLOCK_SIZE)) * PROD_W'(FOCAL);
        s1_bz <= bz;
    end

    ////////////////////////////////////////////////////////////
    // stage 2: four edge compares, zero depth check
    always_ff @(posedge clk_in) begin
        s2_inside[0] <= s1_cross_x >= s1_lo_x;
        s2_inside[1] <= s1_cross_x < s1_hi_x;
        s2_inside[2] <= s1_cross_y >= s1_lo_y;
        s2_inside[3] <= s1_cross_y < s1_hi_y;
        // face at the eye plane never counts
        s2_bz_nz <= s1_bz != '0;
        s2_bz <= s1_bz;
    end

    ////////////////////////////////////////////////////////////
    // stage 3: combine, depth is the face z
    always_ff @(posedge clk_in) begin
        intersects_out <= (&s2_inside) && s2_bz_nz;
        t_out <= s2_bz;
    end

    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            vld_sr <= '0;
        end else begin
            vld_sr <= {vld_sr[INTERSECT_LAT-2:0], valid_in};
        end
    end

    assign valid_out = vld_sr[INTERSECT_LAT-1];

endmodule

// ==== rtl/get_intersecting_block.sv ====
`timescale 1ns/1ns

module get_intersecting_block import ray_pkg::*; (
    input  logic  clk_in,
    input  logic  rst_in,
    block_if.sink blk,
    hit_if.source res
);

    // ray register stage
    logic                     ray_valid;
    logic signed [DIR_W-1:0]  dir_x;
    logic signed [DIR_W-1:0]  dir_y;
    logic signed [POS_W-1:0]  ray_bx;
    logic signed [POS_W-1:0]  ray_by;
    logic [DEPTH_W-1:0]       ray_bz;

    // index and visible, aligned to the intersect output
    logic [IDX_W-1:0]         idx_pipe [ALIGN_DEPTH];
    logic                     vis_pipe [ALIGN_DEPTH];
    logic                     is_saber;

    // intersect result
    logic                     isect_valid;
    logic                     isect_hit;
    logic [DEPTH_W-1:0]       isect_t;

    ////////////////////////////////////////////////////////////
    // ray generation
    // direction is pixel minus center, z fixed at FOCAL
    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            ray_valid <= 1'b0;
        end else begin
            ray_valid <= blk.valid;
        end
    end

    always_ff @(posedge clk_in) begin
        dir_x <= DIR_W'(blk.px) - DIR_W'(CENTER_X);
        dir_y <= DIR_W'(blk.py) - DIR_W'(CENTER_Y);
        // block position lines up with the ray
        ray_bx <= blk.bx;
        ray_by <= blk.by;
        ray_bz <= blk.bz;
    end

    ////////////////////////////////////////////////////////////
    // alignment delay lines
    always_ff @(posedge clk_in) begin
        idx_pipe[0] <= blk.index;
        vis_pipe[0] <= blk.visible;
        for (int i = 1; i < ALIGN_DEPTH; i++) begin
            idx_pipe[i] <= idx_pipe[i-1];
            vis_pipe[i] <= vis_pipe[i-1];
        end
    end

    // first tap sits beside the ray register
    assign is_saber = idx_pipe[0] == IDX_W'(SABER_INDEX);

    does_ray_block_intersect i_does_ray_block_intersect (
        .clk_in         (clk_in),
        .rst_in         (rst_in),
        .valid_in       (ray_valid),
        .dir_x          (dir_x),
        .dir_y          (dir_y),
        .bx             (ray_bx),
        .by             (ray_by),
        .bz             (ray_bz),
        .is_saber       (is_saber),
        .valid_out      (isect_valid),
        .intersects_out (isect_hit),
        .t_out          (isect_t)
    );

    ////////////////////////////////////////////////////////////
    // output register
    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            res.valid <= 1'b0;
        end else begin
            res.valid <= isect_valid;
        end
    end

    always_ff @(posedge clk_in) begin
        // hidden blocks never hit
        res.hit <= isect_hit && vis_pipe[ALIGN_DEPTH-1];
        res.index <= idx_pipe[ALIGN_DEPTH-1];
        res.t <= isect_t;
    end

endmodule

// ==== rtl/block_selector.sv ====
`timescale 1ns/1ns

module block_selector import ray_pkg::*; (
    input  logic                     clk_in,
    input  logic                     rst_in,
    input  logic                     pixel_valid,
    input  logic [PX_W-1:0]          pixel_x,
    input  logic [PY_W-1:0]          pixel_y,
    input  logic                     wr_en,
    input  logic [IDX_W-1:0]         wr_index,
    input  logic signed [POS_W-1:0]  wr_x,
    input  logic signed [POS_W-1:0]  wr_y,
    input  logic [DEPTH_W-1:0]       wr_z,
    input  logic                     wr_visible,
    output logic                     busy,
    output logic                     result_valid,
    output logic                     result_hit,
    output logic [IDX_W-1:0]         result_index,
    output logic [DEPTH_W-1:0]       result_t,
    block_if.source                  blk,
    hit_if.sink                      res
);

    // block table
    logic signed [POS_W-1:0]  tab_x [NUM_BLOCKS];
    logic signed [POS_W-1:0]  tab_y [NUM_BLOCKS];
    logic [DEPTH_W-1:0]       tab_z [NUM_BLOCKS];
    logic [NUM_BLOCKS-1:0]    tab_vis;

    // sequencer
    sel_state_t               state;
    logic [IDX_W-1:0]         scan_idx;
    logic                     accept;
    logic                     issue;
    logic [IDX_W-1:0]         issue_idx;
    logic                     last_back;
    logic                     take;

    ////////////////////////////////////////////////////////////
    // table writes, visible next cycle
    always_ff @(posedge clk_in) begin
        if (wr_en) begin
            tab_x[wr_index] <= wr_x;
            tab_y[wr_index] <= wr_y;
            tab_z[wr_index] <= wr_z;
        end
    end

    // all blocks hidden out of reset
    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            tab_vis <= '0;
        end else if (wr_en) begin
            tab_vis[wr_index] <= wr_visible;
        end
    end

    ////////////////////////////////////////////////////////////
    // scan sequencer
    // busy also covers the result pulse, so no pixel lands on it
    assign busy = (state != SEL_IDLE) || result_valid;
    assign accept = pixel_valid && !busy;
    // block 0 goes out straight from the accept
    assign issue = accept || (state == SEL_SCAN);
    assign issue_idx = (state == SEL_SCAN) ? scan_idx : '0;
    // blocks come back in order, last index ends the pixel
    assign last_back = res.valid && (res.index == IDX_W'(NUM_BLOCKS - 1));

    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            state <= SEL_IDLE;
            scan_idx <= '0;
            result_valid <= 1'b0;
        end else begin
            result_valid <= 1'b0;
            case (state)
                SEL_IDLE: begin
                    if (accept) begin
                        state <= SEL_SCAN;
                        scan_idx <= IDX_W'(1);
                    end
                end
                SEL_SCAN: begin
                    scan_idx <= scan_idx + 1'b1;
                    if (scan_idx == IDX_W'(NUM_BLOCKS - 1)) begin
                        state <= SEL_DRAIN;
                    end
                end
                SEL_DRAIN: begin
                    // wait out the picker pipeline
                    if (last_back) begin
                        state <= SEL_IDLE;
                        result_valid <= 1'b1;
                    end
                end
                default: begin
                    state <= SEL_IDLE;
                end
            endcase
        end
    end

    ////////////////////////////////////////////////////////////
    // block issue
    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            blk.valid <= 1'b0;
        end else begin
            blk.valid <= issue;
        end
    end

    always_ff @(posedge clk_in) begin
        // pixel held for the whole scan
        if (accept) begin
            blk.px <= pixel_x;
            blk.py <= pixel_y;
        end
        if (issue) begin
            blk.index <= issue_idx;
            blk.bx <= tab_x[issue_idx];
            blk.by <= tab_y[issue_idx];
            blk.bz <= tab_z[issue_idx];
            blk.visible <= tab_vis[issue_idx];
        end
    end

    ////////////////////////////////////////////////////////////
    // nearest hit
    // strict compare, so an equal t keeps the lower index
    assign take = res.valid && res.hit && (!result_hit || (res.t < result_t));

    // running best, final while result_valid is high
    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            result_hit <= 1'b0;
            result_index <= '0;
            result_t <= '0;
        end else if (accept) begin
            result_hit <= 1'b0;
            result_index <= '0;
            result_t <= '0;
        end else if (take) begin
            result_hit <= 1'b1;
            result_index <= res.index;
            result_t <= res.t;
        end
    end

endmodule

// ==== rtl/ray_cast_top.sv ====
`timescale 1ns/1ns

module ray_cast_top import ray_pkg::*; (
    input  logic                     clk_in,
    input  logic                     rst_in,
    input  logic                     pixel_valid,
    input  logic [PX_W-1:0]          pixel_x,
    input  logic [PY_W-1:0]          pixel_y,
    input  logic                     wr_en,
    input  logic [IDX_W-1:0]         wr_index,
    input  logic signed [POS_W-1:0]  wr_x,
    input  logic signed [POS_W-1:0]  wr_y,
    input  logic [DEPTH_W-1:0]       wr_z,
    input  logic                     wr_visible,
    output logic                     busy,
    output logic                     result_valid,
    output logic                     result_hit,
    output logic [IDX_W-1:0]         result_index,
    output logic [DEPTH_W-1:0]       result_t
);

    // selector to picker and back
    block_if blk_bus ();
    hit_if   hit_bus ();

    // table, scan and nearest pick
    block_selector i_block_selector (
        .clk_in       (clk_in),
        .rst_in       (rst_in),
        .pixel_valid  (pixel_valid),
        .pixel_x      (pixel_x),
        .pixel_y      (pixel_y),
        .wr_en        (wr_en),
        .wr_index     (wr_index),
        .wr_x         (wr_x),
        .wr_y         (wr_y),
        .wr_z         (wr_z),
        .wr_visible   (wr_visible),
        .busy         (busy),
        .result_valid (result_valid),
        .result_hit   (result_hit),
        .result_index (result_index),
        .result_t     (result_t),
        .blk          (blk_bus),
        .res          (hit_bus)
    );

    // per-block ray test
    get_intersecting_block i_get_intersecting_block (
        .clk_in (clk_in),
        .rst_in (rst_in),
        .blk    (blk_bus),
        .res    (hit_bus)
    );

endmodule

// ==== bench/ray_cast_tb.sv ====
`timescale 1ns/1ns

module ray_cast_tb import ray_pkg::*; ();

    // run length, sizes the watchdog
    localparam int RESET_CYCLES = 16;
    localparam int RANDOM_TABLES = 3;
    localparam int PIXELS_PER_TABLE = 100;
    localparam int DIRECTED_PIXELS = 16;
    localparam int WRITE_BUDGET = 160;
    localparam int WATCHDOG_CYCLES = RESET_CYCLES + WRITE_BUDGET * 2
        + (RANDOM_TABLES * PIXELS_PER_TABLE + DIRECTED_PIXELS) * 30;
    // negedge samples from accept to result_valid, busy high on all of them
    localparam int RESULT_LATENCY = 22;
    localparam int RESULT_TIMEOUT = 40;

    logic                     clk_in;
    logic                     rst_in;
    logic                     pixel_valid;
    logic [PX_W-1:0]          pixel_x;
    logic [PY_W-1:0]          pixel_y;
    logic                     wr_en;
    logic [IDX_W-1:0]         wr_index;
    logic signed [POS_W-1:0]  wr_x;
    logic signed [POS_W-1:0]  wr_y;
    logic [DEPTH_W-1:0]       wr_z;
    logic                     wr_visible;
    logic                     busy;
    logic                     result_valid;
    logic                     result_hit;
    logic [IDX_W-1:0]         result_index;
    logic [DEPTH_W-1:0]       result_t;

    // model copy of the block table
    int m_x [NUM_BLOCKS];
    int m_y [NUM_BLOCKS];
    int m_z [NUM_BLOCKS];
    bit m_vis [NUM_BLOCKS];
    bit exp_hit;
    int exp_index;
    int exp_t;

    logic [31:0] lfsr_state = 32'h0def_46f1;
    int accepted_count = 0;
    int pulse_count = 0;
    int random_hits = 0;

    ray_cast_top i_ray_cast_top (.*);

    initial begin
        clk_in = 1'b0;
        forever #2 clk_in = ~clk_in;
    end

    // one count per result pulse
    always @(negedge clk_in) begin
        if (!rst_in && result_valid) begin
            pulse_count++;
        end
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk_in);
        $display("watchdog expired after %0d cycles", WATCHDOG_CYCLES);
        $display("TESTBENCH FAILED");
        $fatal(1, "run did not finish");
    end

    ////////////////////////////////////////////////////////////
    // random numbers, x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        logic fb;
        fb = s[31] ^ s[21] ^ s[1] ^ s[0];
        return {s[30:0], fb};
    endfunction

    // one step per bit taken
    function automatic int rand_bits(input int n);
        int r;
        r = 0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            r = (r << 1) | int'(lfsr_state[0]);
        end
        return r;
    endfunction

    task automatic compare(input string name, input longint expected, input longint actual);
        if (expected != actual) begin
            $display("MISMATCH %s expected %0d actual %0d", name, expected, actual);
            $display("TESTBENCH FAILED");
            $fatal(1, "stopping at the first error");
        end
    endtask

    ////////////////////////////////////////////////////////////
    // reference model
    // front face hit by cross multiply, depth is the face z
    function automatic bit ray_hits(input int idx, input int px, input int py);
        longint dx;
        longint dy;
        longint z;
        longint w;
        bit in_x;
        bit in_y;
        dx = px - CENTER_X;
        dy = py - CENTER_Y;
        z = m_z[idx];
        // saber is thin in x only
        w = (idx == SABER_INDEX) ? SABER_WIDTH : BLOCK_SIZE;
        in_x = (dx * z >= m_x[idx] * FOCAL) && (dx * z < (m_x[idx] + w) * FOCAL);
        in_y = (dy * z >= m_y[idx] * FOCAL) && (dy * z < (m_y[idx] + BLOCK_SIZE) * FOCAL);
        return m_vis[idx] && (z != 0) && in_x && in_y;
    endfunction

    // smallest t wins, equal t keeps the lower index
    task automatic predict(input int px, input int py);
        exp_hit = 0;
        exp_index = 0;
        exp_t = 0;
        for (int i = 0; i < NUM_BLOCKS; i++) begin
            if (ray_hits(i, px, py) && (!exp_hit || m_z[i] < exp_t)) begin
                exp_hit = 1;
                exp_index = i;
                exp_t = m_z[i];
            end
        end
    endtask

    ////////////////////////////////////////////////////////////
    // stimulus
    task automatic write_block(input int idx, input int x, input int y, input int z,
                               input bit vis);
        @(posedge clk_in);
        wr_en <= 1'b1;
        wr_index <= IDX_W'(idx);
        wr_x <= POS_W'(x);
        wr_y <= POS_W'(y);
        wr_z <= DEPTH_W'(z);
        wr_visible <= vis;
        @(posedge clk_in);
        wr_en <= 1'b0;
        m_x[idx] = x;
        m_y[idx] = y;
        m_z[idx] = z;
        m_vis[idx] = vis;
    endtask

    task automatic clear_table();
        for (int i = 0; i < NUM_BLOCKS; i++) begin
            write_block(i, 0, 0, 0, 1'b0);
        end
    endtask

    task automatic load_random_table();
        int z;
        int zr;
        int x;
        int y;
        for (int i = 0; i < NUM_BLOCKS; i++) begin
            z = 64 + rand_bits(9);
            // now and then a face on the eye plane
            if (rand_bits(4) == 0) begin
                z = 0;
            end
            zr = (z == 0) ? 64 : z;
            // keep the face inside the view at that depth
            x = (rand_bits(12) % (2 * zr)) - zr - 32;
            y = (rand_bits(12) % (3 * zr / 2)) - (3 * zr / 4) - 32;
            write_block(i, x, y, z, rand_bits(2) != 0);
        end
    endtask

    // poke raises pixel_valid again while the scan runs
    task automatic run_pixel(input string name, input int px, input int py, input bit poke);
        int cycles;
        bit done;
        cycles = 0;
        done = 0;
        predict(px, py);
        @(negedge clk_in);
        compare({name, " idle"}, 0, longint'(busy));
        @(posedge clk_in);
        pixel_valid <= 1'b1;
        pixel_x <= PX_W'(px);
        pixel_y <= PY_W'(py);
        // accept edge
        @(posedge clk_in);
        pixel_valid <= 1'b0;
        accepted_count++;
        while (!done) begin
            @(negedge clk_in);
            cycles++;
            compare({name, " busy"}, 1, longint'(busy));
            if (result_valid) begin
                done = 1;
            end else if (cycles >= RESULT_TIMEOUT) begin
                $display("%s got no result_valid within %0d cycles", name, RESULT_TIMEOUT);
                $display("TESTBENCH FAILED");
                $fatal(1, "result never came back");
            end else begin
                @(posedge clk_in);
                if (poke) begin
                    pixel_valid <= (cycles >= 2) && (cycles < 10);
                    pixel_x <= PX_W'(rand_bits(10));
                end
            end
        end
        compare({name, " latency"}, RESULT_LATENCY, cycles);
        compare({name, " hit"}, exp_hit, longint'(result_hit));
        compare({name, " index"}, exp_index, longint'(result_index));
        compare({name, " t"}, exp_t, longint'(result_t));
        if (exp_hit) begin
            random_hits++;
        end
        // one cycle pulse, then idle
        @(negedge clk_in);
        compare({name, " pulse end"}, 0, longint'(result_valid));
        compare({name, " busy end"}, 0, longint'(busy));
    endtask

    ////////////////////////////////////////////////////////////
    // test sequence
    initial begin
        rst_in <= 1'b1;
        pixel_valid <= 1'b0;
        pixel_x <= '0;
        pixel_y <= '0;
        wr_en <= 1'b0;
        wr_index <= '0;
        wr_x <= '0;
        wr_y <= '0;
        wr_z <= '0;
        wr_visible <= 1'b0;
        for (int i = 0; i < NUM_BLOCKS; i++) begin
            m_x[i] = 0;
            m_y[i] = 0;
            m_z[i] = 0;
            m_vis[i] = 0;
        end
        repeat (RESET_CYCLES) @(posedge clk_in);
        rst_in <= 1'b0;

        // empty table after reset
        run_pixel("reset", rand_bits(10), rand_bits(9), 1'b0);
        compare("reset miss", 0, longint'(result_hit));

        // random tables, some pixels poked while busy
        for (int t = 0; t < RANDOM_TABLES; t++) begin
            load_random_table();
            for (int p = 0; p < PIXELS_PER_TABLE; p++) begin
                run_pixel($sformatf("random %0d.%0d", t, p), rand_bits(10),
                          rand_bits(10) % SCREEN_H, (p % 7) == 3);
            end
        end
        compare("random some hits", 1, longint'(random_hits > 0));

        // visibility toggle on one block at the center
        clear_table();
        write_block(5, -32, -32, 256, 1'b1);
        run_pixel("vis on", CENTER_X, CENTER_Y, 1'b0);
        compare("vis on hit", 1, longint'(result_hit));
        write_block(5, -32, -32, 256, 1'b0);
        run_pixel("vis off", CENTER_X, CENTER_Y, 1'b0);
        compare("vis off hit", 0, longint'(result_hit));
        write_block(5, -32, -32, 256, 1'b1);
        run_pixel("vis again", CENTER_X, CENTER_Y, 1'b0);
        compare("vis again hit", 1, longint'(result_hit));

        // at z = FOCAL the face spans dx in [0, width)
        clear_table();
        write_block(SABER_INDEX, 0, -32, FOCAL, 1'b1);
        run_pixel("saber inside", CENTER_X + SABER_WIDTH - 1, CENTER_Y, 1'b0);
        compare("saber inside hit", 1, longint'(result_hit));
        run_pixel("saber outside", CENTER_X + SABER_WIDTH, CENTER_Y, 1'b0);
        compare("saber outside hit", 0, longint'(result_hit));
        run_pixel("saber left", CENTER_X - 1, CENTER_Y, 1'b0);
        compare("saber left hit", 0, longint'(result_hit));
        write_block(SABER_INDEX, 0, 0, 0, 1'b0);
        write_block(3, 0, -32, FOCAL, 1'b1);
        run_pixel("block past saber", CENTER_X + SABER_WIDTH, CENTER_Y, 1'b0);
        compare("block past saber hit", 1, longint'(result_hit));
        run_pixel("block inside", CENTER_X + BLOCK_SIZE - 1, CENTER_Y, 1'b0);
        compare("block inside hit", 1, longint'(result_hit));
        run_pixel("block outside", CENTER_X + BLOCK_SIZE, CENTER_Y, 1'b0);
        compare("block outside hit", 0, longint'(result_hit));

        // stacked faces, nearest then lowest index
        clear_table();
        write_block(7, -32, -32, 300, 1'b1);
        write_block(2, -32, -32, 400, 1'b1);
        write_block(9, -32, -32, 200, 1'b1);
        run_pixel("nearest", CENTER_X, CENTER_Y, 1'b0);
        compare("nearest index", 9, longint'(result_index));
        write_block(4, -32, -32, 200, 1'b1);
        run_pixel("tie low", CENTER_X, CENTER_Y, 1'b0);
        compare("tie low index", 4, longint'(result_index));
        write_block(11, -32, -32, 200, 1'b1);
        write_block(1, -32, -32, 100, 1'b0);
        run_pixel("tie high", CENTER_X, CENTER_Y, 1'b0);
        compare("tie high index", 4, longint'(result_index));

        // pokes while busy must not add results
        compare("result pulses", accepted_count, pulse_count);
        $display("TESTBENCH PASSED");
        $finish;
    end

endmodule

// ==== flist.f ====
rtl/ray_pkg.sv
rtl/ray_ifs.sv
rtl/does_ray_block_intersect.sv
rtl/get_intersecting_block.sv
rtl/block_selector.sv
rtl/ray_cast_top.sv
bench/ray_cast_tb.sv

// ==== Makefile ====
TOP = ray_cast_tb
OBJ = obj_dir

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing -Wno-fatal --top-module $(TOP) --Mdir $(OBJ) -f flist.f

# pass only when the pass line shows up in the output
run: build
	@out="$$(./$(OBJ)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "TESTBENCH PASSED"

lint:
	verilator --lint-only --timing -Wall --top-module ray_cast_top -f flist.f

clean:
	rm -rf $(OBJ)
